// File: logic/mac_rd_defs.svh
`ifndef MAC_RD_DEFS_SVH
`define MAC_RD_DEFS_SVH

//////////////////////////////////////////////////////////////////////
// bus timing

// clk cycles per quarter scl period, kept small for short runs
`define MAC_RD_QUARTER 4

//////////////////////////////////////////////////////////////////////
// eeprom layout

`define MAC_RD_WORD_ADDR 8'h9A // start of the eui-48 field
`define MAC_RD_LEN 6 // bytes per read burst
`define MAC_RD_DEV_TYPE 4'b1011 // fixed upper nibble of device addr

`endif

// File: logic/mac_rd_pkg.sv
`default_nettype none

package mac_rd_pkg;

	//////////////////////////////////////////////////////////////////////
	// widths

	typedef logic [7:0] byte_t; // one bus data byte
	typedef logic [47:0] mac_t; // assembled mac, first byte on top
	typedef logic [6:0] dev_addr_t; // 7-bit i2c slave address

	//////////////////////////////////////////////////////////////////////
	// register reader to byte engine

	typedef enum logic [2:0] {
		op_start,
		op_restart,
		op_stop,
		op_send,
		op_recv
	} i2c_op_e;

	typedef struct packed {
		i2c_op_e op;
		byte_t wdata; // send only
		logic last; // recv only, answer with nack
	} i2c_cmd_t;

	typedef struct packed {
		byte_t rdata; // recv result
		logic nack; // slave did not ack a sent byte
	} i2c_rsp_t;

	//////////////////////////////////////////////////////////////////////
	// state machines

	typedef enum logic [2:0] {
		rd_idle, rd_start, rd_wr_addr, rd_word, rd_restart, rd_rd_addr, rd_recv, rd_stop
	} rd_state_e;

	typedef enum logic [1:0] {fsm_idle, fsm_read, fsm_hold} fsm_state_e;

	typedef enum logic [2:0] {
		eng_idle, eng_start, eng_restart, eng_stop, eng_send, eng_recv
	} eng_state_e;

endpackage

`default_nettype wire

// File: logic/i2c_bit_timer.sv
`timescale 1ns/10ps
`default_nettype none

`include "mac_rd_defs.svh"

module i2c_bit_timer (
	input logic clk,
	input logic arst_n,
	input logic run, // engine busy
	output logic tick // quarter-bit strobe
);

	localparam int cnt_w = $clog2(`MAC_RD_QUARTER + 1);
	localparam logic [cnt_w-1:0] reload_val = cnt_w'(`MAC_RD_QUARTER - 1);

	logic [cnt_w-1:0] cnt; // cycles left in this quarter

	// registered tick, so the first one lands a full quarter after run
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			cnt <= reload_val;
			tick <= 1'b0;
		end else begin
			tick <= 1'b0; // default, single-cycle pulse
			if (!run) begin
				cnt <= reload_val; // parked, restart fresh on next run
			end else if (cnt == '0) begin
				cnt <= reload_val;
				tick <= 1'b1;
			end else begin
				cnt <= cnt - 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

// File: logic/i2c_byte_engine.sv
`timescale 1ns/10ps
`default_nettype none

module i2c_byte_engine (
	input logic clk,
	input logic arst_n,
	input logic cmd_go, // take cmd, only while idle
	input mac_rd_pkg::i2c_cmd_t cmd,
	output logic op_done, // rsp valid this cycle
	output mac_rd_pkg::i2c_rsp_t rsp,
	output logic run, // keeps the timer going
	input logic tick, // quarter-bit strobe
	output logic scl_oe, // high pulls scl low
	output logic sda_oe, // high pulls sda low
	input logic sda_in // resolved line
);

	mac_rd_pkg::eng_state_e state;
	logic [1:0] phase; // quarter within the current bit
	logic [3:0] bit_cnt; // 0..7 data, 8 ack slot
	mac_rd_pkg::byte_t shift_q; // tx data out of msb, rx data into lsb
	logic nack_q;
	logic last_q; // nack the byte being received
	logic sda_meta;
	logic sda_s; // synchronized sda
	logic ack_bit;
	logic is_send;
	logic is_data;
	logic is_cond;

	assign run = (state != mac_rd_pkg::eng_idle);
	assign ack_bit = (bit_cnt == 4'd8);
	assign is_send = (state == mac_rd_pkg::eng_send);
	assign is_data = is_send || (state == mac_rd_pkg::eng_recv);
	assign is_cond = run && !is_data; // start, restart or stop
	assign rsp = '{rdata: shift_q, nack: nack_q};

	//////////////////////////////////////////////////////////////////////
	// data path

	always_ff @(posedge clk) begin
		sda_meta <= sda_in;
		sda_s <= sda_meta;
		if (cmd_go && !run) begin
			shift_q <= cmd.wdata;
			last_q <= cmd.last;
			nack_q <= 1'b0;
		end else if (tick && is_data && phase == 2'd2) begin // middle of scl high
			if (ack_bit)
				nack_q <= is_send && sda_s; // released line means no ack
			else
				shift_q <= {shift_q[6:0], sda_s};
		end
	end

	//////////////////////////////////////////////////////////////////////
	// bus waveforms, one action per quarter tick

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state <= mac_rd_pkg::eng_idle;
			phase <= 2'd0;
			bit_cnt <= 4'd0;
			scl_oe <= 1'b0;
			sda_oe <= 1'b0;
			op_done <= 1'b0;
		end else begin
			op_done <= 1'b0;
			if (!run) begin
				if (cmd_go) begin
					phase <= 2'd0;
					bit_cnt <= 4'd0;
					case (cmd.op)
						mac_rd_pkg::op_start: state <= mac_rd_pkg::eng_start;
						mac_rd_pkg::op_restart: state <= mac_rd_pkg::eng_restart;
						mac_rd_pkg::op_stop: state <= mac_rd_pkg::eng_stop;
						mac_rd_pkg::op_send: state <= mac_rd_pkg::eng_send;
						default: state <= mac_rd_pkg::eng_recv;
					endcase
				end
			end else if (tick) begin
				phase <= phase + 2'd1;
				case (state)
					mac_rd_pkg::eng_start: begin // bus idle, both lines high
						case (phase)
							2'd0: sda_oe <= 1'b0;
							2'd1: sda_oe <= 1'b1; // sda falls under high scl
							2'd2: ;
							default: scl_oe <= 1'b1;
						endcase
					end
					mac_rd_pkg::eng_restart: begin // scl low after an ack slot
						case (phase)
							2'd0: sda_oe <= 1'b0; // release sda first
							2'd1: scl_oe <= 1'b0;
							2'd2: sda_oe <= 1'b1; // repeated start
							default: scl_oe <= 1'b1;
						endcase
					end
					mac_rd_pkg::eng_stop: begin
						case (phase)
							2'd0: sda_oe <= 1'b1; // sda low while scl low
							2'd1: scl_oe <= 1'b0;
							2'd2: sda_oe <= 1'b0; // sda rises under high scl
							default: ;
						endcase
					end
					default: begin // send or recv, 9 bits
						case (phase)
							2'd0: begin
								if (ack_bit)
									sda_oe <= !is_send && !last_q; // our ack on recv
								else
									sda_oe <= is_send && !shift_q[7];
							end
							2'd1: scl_oe <= 1'b0;
							2'd2: ; // sample, see data path
							default: begin
								scl_oe <= 1'b1;
								bit_cnt <= bit_cnt + 4'd1;
							end
						endcase
					end
				endcase
				if (phase == 2'd3 && (is_cond || ack_bit)) begin
					state <= mac_rd_pkg::eng_idle;
					op_done <= 1'b1; // one cycle after the final tick
				end
			end
		end
	end

endmodule

`default_nettype wire

// File: logic/eeprom_reg_reader.sv
`timescale 1ns/10ps
`default_nettype none

`include "mac_rd_defs.svh"

module eeprom_reg_reader #(
	parameter logic [2:0] addr_pins = 3'd0 // strap of a2..a0
) (
	input logic clk,
	input logic arst_n,
	input logic open, // begin a burst
	output logic rdata_valid,
	output mac_rd_pkg::byte_t rdata,
	output logic burst_done, // stop has finished
	output logic err, // some byte went unacked
	output logic cmd_go,
	output mac_rd_pkg::i2c_cmd_t cmd,
	input logic op_done,
	input mac_rd_pkg::i2c_rsp_t rsp
);

	localparam int cnt_w = $clog2(`MAC_RD_LEN + 1);
	localparam logic [cnt_w-1:0] last_idx = cnt_w'(`MAC_RD_LEN - 1);
	localparam mac_rd_pkg::dev_addr_t dev_addr = {`MAC_RD_DEV_TYPE, addr_pins};

	mac_rd_pkg::rd_state_e state;
	logic [cnt_w-1:0] byte_cnt; // receives done so far
	logic last_byte;

	assign last_byte = (byte_cnt == last_idx);
	assign rdata_valid = op_done && (state == mac_rd_pkg::rd_recv);
	assign rdata = rsp.rdata;

	// command follows the state, sampled by the engine on cmd_go
	always_comb begin
		cmd = '{op: mac_rd_pkg::op_stop, wdata: 8'h00, last: 1'b0};
		case (state)
			mac_rd_pkg::rd_start: cmd.op = mac_rd_pkg::op_start;
			mac_rd_pkg::rd_wr_addr: begin
				cmd.op = mac_rd_pkg::op_send;
				cmd.wdata = {dev_addr, 1'b0}; // write bit
			end
			mac_rd_pkg::rd_word: begin
				cmd.op = mac_rd_pkg::op_send;
				cmd.wdata = `MAC_RD_WORD_ADDR;
			end
			mac_rd_pkg::rd_restart: cmd.op = mac_rd_pkg::op_restart;
			mac_rd_pkg::rd_rd_addr: begin
				cmd.op = mac_rd_pkg::op_send;
				cmd.wdata = {dev_addr, 1'b1}; // read bit
			end
			mac_rd_pkg::rd_recv: begin
				cmd.op = mac_rd_pkg::op_recv;
				cmd.last = last_byte; // nack ends the read
			end
			default: ;
		endcase
	end

	//////////////////////////////////////////////////////////////////////
	// op sequencer

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state <= mac_rd_pkg::rd_idle;
			byte_cnt <= '0;
			cmd_go <= 1'b0;
			burst_done <= 1'b0;
			err <= 1'b0;
		end else begin
			cmd_go <= 1'b0;
			burst_done <= 1'b0;
			if (state == mac_rd_pkg::rd_idle) begin
				if (open) begin
					state <= mac_rd_pkg::rd_start;
					cmd_go <= 1'b1; // first op the cycle after open
					err <= 1'b0;
					byte_cnt <= '0;
				end
			end else if (op_done) begin
				cmd_go <= 1'b1; // next op, cleared again below on exit
				case (state)
					mac_rd_pkg::rd_start: state <= mac_rd_pkg::rd_wr_addr;
					mac_rd_pkg::rd_wr_addr, mac_rd_pkg::rd_word, mac_rd_pkg::rd_rd_addr: begin
						if (rsp.nack) begin
							state <= mac_rd_pkg::rd_stop; // abort
							err <= 1'b1;
						end else if (state == mac_rd_pkg::rd_wr_addr) begin
							state <= mac_rd_pkg::rd_word;
						end else if (state == mac_rd_pkg::rd_word) begin
							state <= mac_rd_pkg::rd_restart;
						end else begin
							state <= mac_rd_pkg::rd_recv;
						end
					end
					mac_rd_pkg::rd_restart: state <= mac_rd_pkg::rd_rd_addr;
					mac_rd_pkg::rd_recv: begin
						if (last_byte)
							state <= mac_rd_pkg::rd_stop;
						else
							byte_cnt <= byte_cnt + 1'b1;
					end
					default: begin // stop finished
						state <= mac_rd_pkg::rd_idle;
						cmd_go <= 1'b0;
						burst_done <= 1'b1;
					end
				endcase
			end
		end
	end

endmodule

`default_nettype wire

// File: logic/mac_addr_fsm.sv
`timescale 1ns/10ps
`default_nettype none

module mac_addr_fsm (
	input logic clk,
	input logic arst_n,
	input logic start, // request a read
	output logic busy,
	output logic done,
	output logic err,
	output mac_rd_pkg::mac_t mac,
	output logic open, // kick the register reader
	input logic rdata_valid,
	input mac_rd_pkg::byte_t rdata,
	input logic burst_done,
	input logic rd_err
);

	localparam int mac_w = $bits(mac_rd_pkg::mac_t);

	mac_rd_pkg::fsm_state_e state;
	mac_rd_pkg::mac_t staging; // bytes of the burst in flight

	assign busy = (state == mac_rd_pkg::fsm_read);

	// first byte ends up on top after all shifts
	always_ff @(posedge clk) begin
		if (busy && rdata_valid)
			staging <= {staging[mac_w-9:0], rdata};
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state <= mac_rd_pkg::fsm_idle;
			open <= 1'b0;
			done <= 1'b0;
			err <= 1'b0;
			mac <= '0;
		end else begin
			open <= 1'b0;
			case (state)
				mac_rd_pkg::fsm_read: begin // start ignored here
					if (burst_done) begin
						state <= mac_rd_pkg::fsm_hold;
						done <= 1'b1;
						err <= rd_err;
						if (!rd_err)
							mac <= staging; // failed read keeps old mac
					end
				end
				default: begin // idle or hold
					if (start) begin
						state <= mac_rd_pkg::fsm_read;
						open <= 1'b1;
						done <= 1'b0;
						err <= 1'b0;
					end
				end
			endcase
		end
	end

endmodule

`default_nettype wire

// File: logic/mac_addr_reader.sv
`timescale 1ns/10ps
`default_nettype none

module mac_addr_reader #(
	parameter logic [2:0] addr_pins = 3'd0 // board strap of the eeprom
) (
	input logic clk,
	input logic arst_n,
	input logic start,
	output logic busy,
	output logic done,
	output logic err,
	output mac_rd_pkg::mac_t mac,
	output logic scl_oe,
	output logic sda_oe,
	input logic sda_in
);

	logic open;
	logic rdata_valid;
	mac_rd_pkg::byte_t rdata;
	logic burst_done;
	logic rd_err;
	logic cmd_go;
	mac_rd_pkg::i2c_cmd_t cmd;
	logic op_done;
	mac_rd_pkg::i2c_rsp_t rsp;
	logic run;
	logic tick;

	//////////////////////////////////////////////////////////////////////
	// control

	mac_addr_fsm fsm_i (
		.clk, .arst_n, .start, .busy, .done, .err, .mac,
		.open, .rdata_valid, .rdata, .burst_done, .rd_err
	);

	eeprom_reg_reader #(.addr_pins(addr_pins)) reader_i (
		.clk, .arst_n, .open, .rdata_valid, .rdata, .burst_done,
		.err(rd_err), .cmd_go, .cmd, .op_done, .rsp
	);

	//////////////////////////////////////////////////////////////////////
	// bus side

	i2c_byte_engine engine_i (
		.clk, .arst_n, .cmd_go, .cmd, .op_done, .rsp,
		.run, .tick, .scl_oe, .sda_oe, .sda_in
	);

	i2c_bit_timer timer_i (.clk, .arst_n, .run, .tick);

endmodule

`default_nettype wire

// File: sim/tb_clk_gen.sv
`timescale 1ns/10ps
`default_nettype none

module tb_clk_gen (
	output logic clk,
	output logic arst_n
);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk; // 8 ns period
	end

	initial begin
		arst_n = 1'b0;
		#16 arst_n = 1'b1; // two cycles, released on a falling edge
	end

endmodule

`default_nettype wire

// File: sim/eeprom_model.sv
`timescale 1ns/10ps
`default_nettype none

`include "mac_rd_defs.svh"

module eeprom_model #(
	parameter logic [6:0] dev_addr = 7'b1011101
) (
	input wire scl,
	input wire sda,
	input logic present, // low means no ack to any address
	output logic sda_oe // high pulls sda low
);

	logic [7:0] mem [0:255];
	logic [7:0] ptr = 8'h00; // current word address
	logic [7:0] last_word = 8'h00; // word address of the last write phase
	logic [7:0] shreg = 8'h00;
	logic [3:0] bit_cnt = 4'd0; // 8 is the ack slot
	logic [1:0] wr_phase = 2'd0; // 0 device addr, 1 word addr, 2 data
	logic active = 1'b0;
	logic reading = 1'b0; // slave is sending
	logic rd_pending = 1'b0; // read bit seen, switch after the ack
	logic done_rd = 1'b0; // master nacked, wait for stop
	logic skip_fall = 1'b0;
	logic read_nacked = 1'b0;
	logic stop_after_nack = 1'b0;
	logic [`MAC_RD_LEN-1:0] acks = '0; // master ack per read byte
	int rd_idx = 0;
	int ack_errs = 0; // acks that differ from ack-all-but-last
	logic scl_q = 1'b1;
	logic sda_q = 1'b1;

	initial begin
		sda_oe = 1'b0;
		for (int i = 0; i < 256; i++)
			mem[i] = 8'(i) ^ 8'hA5; // background, every address differs
	end

	//////////////////////////////////////////////////////////////////////
	// bus slave, one pass per line change

	always @(scl or sda) begin
		if (scl === 1'b1 && scl_q === 1'b1 && sda !== sda_q) begin
			if (sda === 1'b0) begin // start or repeated start
				active = 1'b1;
				reading = 1'b0;
				rd_pending = 1'b0;
				done_rd = 1'b0;
				read_nacked = 1'b0;
				stop_after_nack = 1'b0;
				skip_fall = 1'b1; // next scl fall closes the start
				bit_cnt = 4'd0;
				wr_phase = 2'd0;
				sda_oe = 1'b0;
			end else begin // stop
				stop_after_nack = read_nacked;
				active = 1'b0;
				sda_oe = 1'b0;
			end
		end else if (scl === 1'b1 && scl_q !== 1'b1 && active && !done_rd) begin
			if (!reading && bit_cnt < 4'd8) begin
				shreg = {shreg[6:0], sda === 1'b1};
			end else if (reading && bit_cnt == 4'd8) begin // master ack slot
				if (rd_idx < `MAC_RD_LEN)
					acks[rd_idx] = (sda === 1'b0);
				if ((sda === 1'b0) != (rd_idx < `MAC_RD_LEN - 1))
					ack_errs++;
				read_nacked = (sda !== 1'b0);
			end
		end else if (scl === 1'b0 && scl_q === 1'b1 && skip_fall) begin
			skip_fall = 1'b0;
		end else if (scl === 1'b0 && scl_q === 1'b1 && active && !done_rd) begin
			if (bit_cnt < 4'd7) begin
				bit_cnt = bit_cnt + 4'd1;
				if (reading) begin
					shreg = shreg << 1;
					sda_oe = !shreg[7]; // next data bit, msb first
				end
			end else if (bit_cnt == 4'd7) begin
				bit_cnt = 4'd8;
				sda_oe = 1'b0; // free the line for the master ack
				if (!reading) begin
					case (wr_phase)
						2'd0: begin
							if (present && shreg[7:1] == dev_addr) begin
								sda_oe = 1'b1;
								rd_pending = shreg[0];
								wr_phase = 2'd1;
							end else begin
								active = 1'b0; // not us, keep off the bus
							end
						end
						2'd1: begin
							ptr = shreg;
							last_word = shreg;
							sda_oe = 1'b1;
							wr_phase = 2'd2;
						end
						default: sda_oe = 1'b1; // data writes acked and dropped
					endcase
				end
			end else begin // end of the ack slot
				sda_oe = 1'b0;
				if (reading && read_nacked) begin
					done_rd = 1'b1;
				end else begin
					if (reading) begin
						ptr = ptr + 8'd1;
						rd_idx++;
					end else if (rd_pending) begin
						reading = 1'b1;
						rd_idx = 0;
						acks = '0;
					end
					bit_cnt = 4'd0;
					if (reading) begin
						shreg = mem[ptr];
						sda_oe = !shreg[7];
					end
				end
			end
		end
		scl_q = scl;
		sda_q = sda;
	end

endmodule

`default_nettype wire

// File: sim/mac_addr_reader_checker.sv
`timescale 1ns/10ps
`default_nettype none

module mac_addr_reader_checker (
	input logic clk,
	input logic arst_n,
	input logic start,
	input logic busy,
	input logic done,
	input logic err,
	input logic scl_oe,
	input logic sda_oe,
	input logic sda_in,
	input logic bus_cond // engine runs a start, restart or stop
);

	int fail_cnt = 0; // assertion failures so far

	// line change under high scl only while a start, restart or stop is on the bus
	sda_hold_a: assert property (@(posedge clk) disable iff (!arst_n)
		(!scl_oe && !$past(scl_oe) && sda_in != $past(sda_in)) |-> bus_cond)
	else begin
		fail_cnt++;
		$error("sda moved while scl was high outside a start or stop");
	end

	done_busy_a: assert property (@(posedge clk) disable iff (!arst_n) !(done && busy))
	else begin
		fail_cnt++;
		$error("done and busy high together");
	end

	err_done_a: assert property (@(posedge clk) disable iff (!arst_n) err |-> done)
	else begin
		fail_cnt++;
		$error("err high without done");
	end

	// accepted start shows up as busy one cycle later
	start_busy_a: assert property (@(posedge clk) disable iff (!arst_n) start && !busy |=> busy)
	else begin
		fail_cnt++;
		$error("start while idle did not raise busy");
	end

endmodule

`default_nettype wire

// File: sim/mac_addr_reader_tb.sv
`timescale 1ns/10ps
`default_nettype none

`include "mac_rd_defs.svh"

module mac_addr_reader_tb;

	// start, restart, stop plus three sends and six receives, a few cycles per op
	localparam int burst_cycles = (3 * 4 + 9 * 36) * `MAC_RD_QUARTER + 12 * 3;
	localparam int n_bursts = 8;
	localparam int cycle_limit = 8 * burst_cycles * n_bursts;
	localparam logic [7:0] eui_addr = 8'h9A; // eui-48 field in the eeprom

	logic clk;
	logic arst_n;
	logic start;
	logic busy;
	logic done;
	logic err;
	mac_rd_pkg::mac_t mac;
	logic scl_oe;
	logic sda_oe;
	logic mem_sda_oe; // model side of the wired-and
	logic present;
	wire scl = !scl_oe; // pulled up, low while driven
	wire sda = !(sda_oe || mem_sda_oe);

	logic [31:0] rng_state = 32'd42028;
	mac_rd_pkg::mac_t expected; // model bytes from 0x9a up, first on top
	int checks = 0;
	int errors = 0;
	int cycles = 0;
	int done_rises = 0;
	logic done_q = 1'b0;

	tb_clk_gen clk_gen_i (.clk, .arst_n);

	mac_addr_reader #(.addr_pins(3'd5)) mac_addr_reader_i (
		.clk, .arst_n, .start, .busy, .done, .err, .mac, .scl_oe, .sda_oe, .sda_in(sda)
	);

	eeprom_model #(.dev_addr(7'b1011101)) eeprom_i (
		.scl, .sda, .present, .sda_oe(mem_sda_oe)
	);

	bind mac_addr_reader mac_addr_reader_checker checker_i (
		.clk, .arst_n, .start, .busy, .done, .err, .scl_oe, .sda_oe, .sda_in,
		.bus_cond(engine_i.is_cond)
	);

	//////////////////////////////////////////////////////////////////////
	// helpers

	function automatic logic [31:0] lcg_next();
		rng_state = rng_state * 32'd1664525 + 32'd1013904223;
		return rng_state;
	endfunction

	task automatic check_val(input string name, input logic [63:0] got, input logic [63:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("mismatch %s: got %h, expected %h", name, got, exp);
		end
	endtask

	// fresh eui-48 in the model, reference follows it
	task automatic fill_memory();
		logic [31:0] r;
		for (int i = 0; i < `MAC_RD_LEN; i++) begin
			r = lcg_next();
			eeprom_i.mem[eui_addr + i] = r[23:16];
			expected = {expected[39:0], r[23:16]};
		end
	endtask

	task automatic idle_gap();
		logic [31:0] r;
		r = lcg_next();
		repeat (r[20:16]) @(negedge clk); // 0..31 cycles
	endtask

	task automatic pulse_start();
		start = 1'b1;
		@(negedge clk);
		start = 1'b0;
	endtask

	// returns on the falling edge where done is first seen
	task automatic run_read();
		pulse_start();
		check_val("busy", busy, 1);
		check_val("done", done, 0); // cleared while busy
		while (!done)
			@(negedge clk);
	endtask

	task automatic end_test(input string name, input int errs_before);
		if (errors == errs_before)
			$display("test %s: ok", name);
		else
			$display("test %s: failed with %0d errors", name, errors - errs_before);
	endtask

	//////////////////////////////////////////////////////////////////////
	// monitors

	always @(negedge clk) begin
		done_q <= done;
		if (done && !done_q)
			done_rises <= done_rises + 1;
	end

	always @(negedge clk) begin
		cycles++;
		if (cycles > cycle_limit) begin
			$display("timeout: no result after %0d cycles", cycles);
			$display("Checks failed");
			$finish;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// tests

	initial begin
		int errs;
		int rises;
		mac_rd_pkg::mac_t prev;
		logic [31:0] r;
		start = 1'b0;
		present = 1'b1;
		@(posedge arst_n);
		@(negedge clk);
		check_val("busy", busy, 0); // reset values
		check_val("done", done, 0);
		check_val("err", err, 0);
		check_val("scl_oe", scl_oe, 0);
		check_val("sda_oe", sda_oe, 0);
		check_val("mac", mac, 0);
		fill_memory();

		errs = errors;
		idle_gap();
		run_read();
		check_val("err", err, 0);
		check_val("mac", mac, expected);
		check_val("word_addr", eeprom_i.last_word, eui_addr);
		end_test("basic_read", errs);

		errs = errors;
		repeat (4) begin
			fill_memory();
			idle_gap();
			run_read();
			check_val("err", err, 0);
			check_val("mac", mac, expected);
		end
		end_test("repeated_reads", errs);

		errs = errors;
		prev = expected;
		fill_memory(); // a stray copy would show this value
		present = 1'b0;
		idle_gap();
		run_read();
		check_val("err", err, 1);
		check_val("mac", mac, prev);
		end_test("missing_device", errs);

		errs = errors;
		present = 1'b1;
		idle_gap();
		run_read();
		check_val("err", err, 0);
		check_val("mac", mac, expected);
		end_test("recovery", errs);

		errs = errors;
		fill_memory();
		idle_gap();
		rises = done_rises;
		pulse_start();
		r = lcg_next();
		repeat (r[25:16] + 1) @(negedge clk); // well inside one burst
		check_val("busy", busy, 1);
		pulse_start(); // must be ignored
		while (!done)
			@(negedge clk);
		repeat (64) @(negedge clk);
		check_val("done_rises", done_rises - rises, 1);
		check_val("busy", busy, 0);
		check_val("err", err, 0);
		check_val("mac", mac, expected);
		end_test("ignored_start", errs);

		errs = errors;
		check_val("acks", eeprom_i.acks, {1'b0, {(`MAC_RD_LEN - 1){1'b1}}});
		check_val("stop_after_nack", eeprom_i.stop_after_nack, 1);
		check_val("ack_errs", eeprom_i.ack_errs, 0);
		end_test("ack_pattern", errs);

		check_val("assertion_failures", mac_addr_reader_i.checker_i.fail_cnt, 0);
		$display("checks: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("All checks passed");
		else
			$display("Checks failed");
		$finish;
	end

endmodule

`default_nettype wire

// File: vlog.f
+incdir+logic
logic/mac_rd_pkg.sv
logic/i2c_bit_timer.sv
logic/i2c_byte_engine.sv
logic/eeprom_reg_reader.sv
logic/mac_addr_fsm.sv
logic/mac_addr_reader.sv
sim/tb_clk_gen.sv
sim/eeprom_model.sv
sim/mac_addr_reader_checker.sv
sim/mac_addr_reader_tb.sv

// File: Makefile
SRCS := $(filter-out +incdir+%,$(shell cat vlog.f)) logic/mac_rd_defs.svh

.PHONY: run clean

run: obj_dir/Vmac_addr_reader_tb
	@out="$$(./obj_dir/Vmac_addr_reader_tb +verilator+error+limit+100)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "All checks passed"

obj_dir/Vmac_addr_reader_tb: vlog.f $(SRCS)
	verilator --binary --assert -Wno-fatal --top-module mac_addr_reader_tb -f vlog.f

clean:
	rm -rf obj_dir
